//--- ntm_adder_settings.svh
`ifndef NTM_ADDER_SETTINGS_SVH
`define NTM_ADDER_SETTINGS_SVH

////////////////////////////////////////
// Data path widths
////////////////////////////////////////

// Two's complement word width
`define NTM_DATA_SIZE 32

// Vector length and element index width
`define NTM_CONTROL_SIZE 16

// Bits added per clock in the scalar adder
// Has to divide the word width, 4, 16 or 32 also fine
`define NTM_CHUNK_SIZE 8

`endif

//--- ntm_arith_pkg.sv
`include "ntm_adder_settings.svh"

package ntm_arith_pkg;

  ////////////////////////////////////////
  // Scalars
  ////////////////////////////////////////

  // Operand or sum, two's complement
  typedef logic [`NTM_DATA_SIZE-1:0] ntm_word_t;

  // Operation picked per element
  typedef enum logic {
    op_add = 1'b0,
    op_sub = 1'b1
  } ntm_op_t;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // Operand pair handed to the scalar adder
  typedef struct packed {
    ntm_word_t data_a;
    ntm_word_t data_b;
    ntm_op_t   op;
  } ntm_operands_t;

  // Wrapped sum plus signed overflow
  typedef struct packed {
    ntm_word_t sum;
    logic      overflow;
  } ntm_result_t;

endpackage

//--- ntm_ctrl_pkg.sv
`include "ntm_adder_settings.svh"

package ntm_ctrl_pkg;

  // Element count and running element index
  typedef logic [`NTM_CONTROL_SIZE-1:0] ntm_index_t;

  ////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////

  // Vector controller
  // Starter waits for START, input gathers a pair, ender waits on the scalar adder
  typedef enum logic [1:0] {
    st_starter = 2'd0,
    st_input   = 2'd1,
    st_ender   = 2'd2
  } vector_state_t;

  // Scalar chunk-serial adder
  typedef enum logic {
    st_idle = 1'b0,
    st_busy = 1'b1
  } scalar_state_t;

endpackage

//--- ntm_scalar_integer_adder.sv
`timescale 1ns/10ps

`include "ntm_adder_settings.svh"

module ntm_scalar_integer_adder (
  // Global
  input  logic                          CLK,
  input  logic                          RST,

  // Control
  input  logic                          START,
  output logic                          READY,

  // Data
  input  ntm_arith_pkg::ntm_operands_t  OPERANDS,
  output ntm_arith_pkg::ntm_result_t    RESULT
);

  import ntm_arith_pkg::*;
  import ntm_ctrl_pkg::*;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  localparam int DATA_SIZE   = `NTM_DATA_SIZE;
  localparam int CHUNK_SIZE  = `NTM_CHUNK_SIZE;
  localparam int CHUNK_COUNT = DATA_SIZE / CHUNK_SIZE;

  // Counter stays one bit wide when the word is a single chunk
  localparam int COUNT_SIZE = (CHUNK_COUNT > 1) ? $clog2(CHUNK_COUNT) : 1;
  localparam logic [COUNT_SIZE-1:0] LAST_CHUNK = COUNT_SIZE'(CHUNK_COUNT - 1);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  scalar_state_t adder_fsm;

  // Chunk position and carry between chunks
  logic [COUNT_SIZE-1:0] chunk_index;
  logic                  carry_q;

  // Effective operands, shifted right one chunk per cycle
  ntm_word_t data_a_q;
  ntm_word_t data_b_q;

  // Partial sum, chunks enter at the top
  ntm_word_t sum_q;
  ntm_word_t sum_next;

  // Current chunk slice
  logic [CHUNK_SIZE-1:0] chunk_a;
  logic [CHUNK_SIZE-1:0] chunk_b;
  logic [CHUNK_SIZE:0]   chunk_sum;

  logic last_chunk;

  ////////////////////////////////////////
  // Chunk adder
  ////////////////////////////////////////

  assign chunk_a = data_a_q[CHUNK_SIZE-1:0];
  assign chunk_b = data_b_q[CHUNK_SIZE-1:0];

  // Extra top bit is the carry out
  assign chunk_sum = {1'b0, chunk_a} + {1'b0, chunk_b} + {{CHUNK_SIZE{1'b0}}, carry_q};

  // New chunk on top, older chunks move down
  assign sum_next = ntm_word_t'({chunk_sum[CHUNK_SIZE-1:0], sum_q} >> CHUNK_SIZE);

  assign last_chunk = (adder_fsm == st_busy) && (chunk_index == LAST_CHUNK);

  // Final chunk settles in the READY cycle
  assign READY       = last_chunk;
  assign RESULT.sum  = sum_next;

  // Last chunk holds the sign bits of both effective operands and the sum
  // Same operand signs with a flipped sum sign means overflow
  assign RESULT.overflow = (chunk_a[CHUNK_SIZE-1] == chunk_b[CHUNK_SIZE-1]) &&
                           (chunk_sum[CHUNK_SIZE-1] != chunk_a[CHUNK_SIZE-1]);

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      adder_fsm   <= st_idle;
      chunk_index <= '0;
      carry_q     <= 1'b0;
    end else begin
      case (adder_fsm)
        st_idle: begin
          if (START) begin
            // Subtract as a + ~b + 1
            carry_q     <= (OPERANDS.op == op_sub);
            chunk_index <= '0;
            adder_fsm   <= st_busy;
          end
        end
        st_busy: begin
          // Ripple into the next chunk
          carry_q <= chunk_sum[CHUNK_SIZE];
          if (last_chunk) begin
            adder_fsm <= st_idle;
          end else begin
            chunk_index <= chunk_index + 1'b1;
          end
        end
        default: begin
          adder_fsm <= st_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Operand and sum registers
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if ((adder_fsm == st_idle) && START) begin
      data_a_q <= OPERANDS.data_a;
      // B inverted for subtract
      data_b_q <= (OPERANDS.op == op_sub) ? ~OPERANDS.data_b : OPERANDS.data_b;
    end else if (adder_fsm == st_busy) begin
      data_a_q <= data_a_q >> CHUNK_SIZE;
      data_b_q <= data_b_q >> CHUNK_SIZE;
      sum_q    <= sum_next;
    end
  end

endmodule

//--- ntm_vector_integer_adder.sv
`timescale 1ns/10ps

module ntm_vector_integer_adder (
  // Global
  input  logic                        CLK,
  input  logic                        RST,

  // Control
  input  logic                        START,
  output logic                        READY,

  input  ntm_arith_pkg::ntm_op_t      OPERATION,

  input  logic                        DATA_A_IN_ENABLE,
  input  logic                        DATA_B_IN_ENABLE,
  output logic                        DATA_OUT_ENABLE,

  // Data
  input  ntm_ctrl_pkg::ntm_index_t    SIZE_IN,
  input  ntm_arith_pkg::ntm_word_t    DATA_A_IN,
  input  ntm_arith_pkg::ntm_word_t    DATA_B_IN,
  output ntm_arith_pkg::ntm_result_t  RESULT
);

  import ntm_arith_pkg::*;
  import ntm_ctrl_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Element loop controller
  vector_state_t adder_ctrl_fsm;

  // Sampled vector length and current element
  ntm_index_t size_q;
  ntm_index_t index_loop;

  // Operand holding flags
  logic data_a_held;
  logic data_b_held;

  // Pair under collection, also the scalar adder input
  ntm_operands_t operands_q;

  // Decoded events
  logic accept_a;
  logic accept_b;
  logic launch;
  logic element_done;
  logic last_element;

  // Scalar adder
  logic        scalar_start;
  logic        scalar_ready;
  ntm_result_t scalar_result;

  ////////////////////////////////////////
  // Event decode
  ////////////////////////////////////////

  // One strobe per operand and element, later strobes dropped
  assign accept_a = (adder_ctrl_fsm == st_input) && DATA_A_IN_ENABLE && !data_a_held;
  assign accept_b = (adder_ctrl_fsm == st_input) && DATA_B_IN_ENABLE && !data_b_held;

  // Pair complete, op sampled here
  assign launch = (adder_ctrl_fsm == st_input) && data_a_held && data_b_held;

  // Scalar result valid
  assign element_done = (adder_ctrl_fsm == st_ender) && scalar_ready;

  // Final element of the vector
  assign last_element = (index_loop == size_q - ntm_index_t'(1));

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      adder_ctrl_fsm  <= st_starter;
      size_q          <= '0;
      index_loop      <= '0;
      data_a_held     <= 1'b0;
      data_b_held     <= 1'b0;
      scalar_start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
    end else begin
      // Strobes drop after one cycle
      scalar_start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;

      case (adder_ctrl_fsm)
        st_starter: begin
          // Step 0, wait for a new vector
          if (START) begin
            size_q         <= SIZE_IN;
            index_loop     <= '0;
            adder_ctrl_fsm <= st_input;
          end
        end
        st_input: begin
          // Step 1, gather both operands in any order
          if (accept_a) begin
            data_a_held <= 1'b1;
          end
          if (accept_b) begin
            data_b_held <= 1'b1;
          end
          if (launch) begin
            // Kick the scalar adder for this element
            data_a_held    <= 1'b0;
            data_b_held    <= 1'b0;
            scalar_start   <= 1'b1;
            adder_ctrl_fsm <= st_ender;
          end
        end
        st_ender: begin
          // Step 2, wait for the scalar sum
          if (scalar_ready) begin
            DATA_OUT_ENABLE <= 1'b1;
            if (last_element) begin
              // Vector finished
              READY          <= 1'b1;
              adder_ctrl_fsm <= st_starter;
            end else begin
              index_loop     <= index_loop + ntm_index_t'(1);
              adder_ctrl_fsm <= st_input;
            end
          end
        end
        default: begin
          adder_ctrl_fsm <= st_starter;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Operand and result registers
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (accept_a) begin
      operands_q.data_a <= DATA_A_IN;
    end
    if (accept_b) begin
      operands_q.data_b <= DATA_B_IN;
    end
    if (launch) begin
      operands_q.op <= OPERATION;
    end
    // Held until the next element
    if (element_done) begin
      RESULT <= scalar_result;
    end
  end

  ////////////////////////////////////////
  // Scalar adder
  ////////////////////////////////////////

  ntm_scalar_integer_adder scalar_adder (
    // Global
    .CLK      (CLK),
    .RST      (RST),

    // Control
    .START    (scalar_start),
    .READY    (scalar_ready),

    // Data
    .OPERANDS (operands_q),
    .RESULT   (scalar_result)
  );

endmodule

//--- ntm_vector_integer_adder_checker.sv
`timescale 1ns/10ps

`include "ntm_adder_settings.svh"

module ntm_vector_integer_adder_checker (
  input logic                        CLK,
  input logic                        RST,
  input logic                        START,
  input ntm_ctrl_pkg::ntm_index_t    SIZE_IN,
  input logic                        READY,
  input logic                        DATA_OUT_ENABLE,
  input logic                        scalar_start,
  input logic                        scalar_ready,
  input ntm_ctrl_pkg::vector_state_t adder_ctrl_fsm
);

  import ntm_ctrl_pkg::*;

  // Cycles the scalar adder spends on one word
  localparam int CHUNK_COUNT = `NTM_DATA_SIZE / `NTM_CHUNK_SIZE;

  ////////////////////////////////////////
  // Top-level protocol
  ////////////////////////////////////////

  // Last element flagged only with its own output
  ready_with_output: assert property (
    @(posedge CLK) disable iff (RST) READY |-> DATA_OUT_ENABLE
  ) else $error("READY high without DATA_OUT_ENABLE");

  // Output strobe is a single pulse
  output_single_cycle: assert property (
    @(posedge CLK) disable iff (RST) DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE
  ) else $error("DATA_OUT_ENABLE longer than one cycle");

  // Empty vectors are not allowed
  nonzero_length: assert property (
    @(posedge CLK) disable iff (RST) (START && adder_ctrl_fsm == st_starter) |-> SIZE_IN != '0
  ) else $error("START with a vector length of zero");

  ////////////////////////////////////////
  // Scalar adder
  ////////////////////////////////////////

  // One chunk per cycle, READY exactly CHUNK_COUNT after START
  scalar_latency: assert property (
    @(posedge CLK) disable iff (RST) scalar_ready == $past(scalar_start, CHUNK_COUNT)
  ) else $error("scalar READY not CHUNK_COUNT cycles after scalar START");

endmodule

bind ntm_vector_integer_adder ntm_vector_integer_adder_checker protocol_checker (
  .CLK             (CLK),
  .RST             (RST),
  .START           (START),
  .SIZE_IN         (SIZE_IN),
  .READY           (READY),
  .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
  .scalar_start    (scalar_start),
  .scalar_ready    (scalar_ready),
  .adder_ctrl_fsm  (adder_ctrl_fsm)
);

//--- ntm_vector_integer_adder_tb.sv
`timescale 1ns/10ps

`include "ntm_adder_settings.svh"

module ntm_vector_integer_adder_tb;

  import ntm_arith_pkg::*;
  import ntm_ctrl_pkg::*;

  ////////////////////////////////////////
  // Constants and types
  ////////////////////////////////////////

  localparam int MSB         = `NTM_DATA_SIZE - 1;
  localparam int CHUNK_COUNT = `NTM_DATA_SIZE / `NTM_CHUNK_SIZE;
  // Held flags, scalar start, chunks, output register
  localparam int LATENCY     = CHUNK_COUNT + 3;
  localparam int WAIT_LIMIT  = 100;

  localparam ntm_word_t WORD_MAX = {1'b0, {MSB{1'b1}}};
  localparam ntm_word_t WORD_MIN = {1'b1, {MSB{1'b0}}};

  // Expected output and whether READY goes with it
  typedef struct packed {
    ntm_result_t result;
    logic        last;
  } expected_t;

  ////////////////////////////////////////
  // DUT and bookkeeping
  ////////////////////////////////////////

  logic        CLK;
  logic        RST;
  logic        START;
  logic        READY;
  ntm_op_t     OPERATION;
  logic        DATA_A_IN_ENABLE;
  logic        DATA_B_IN_ENABLE;
  logic        DATA_OUT_ENABLE;
  ntm_index_t  SIZE_IN;
  ntm_word_t   DATA_A_IN;
  ntm_word_t   DATA_B_IN;
  ntm_result_t RESULT;

  int seed = 32'h8eef99d3;

  // Outstanding elements in arrival order
  expected_t expected_q[$];

  int stim_errors    = 0;
  int compare_errors = 0;
  int tests_passed   = 0;
  int tests_failed   = 0;

  ntm_vector_integer_adder dut (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .READY            (READY),
    .OPERATION        (OPERATION),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .SIZE_IN          (SIZE_IN),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .RESULT           (RESULT)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Inputs change 5 ns after the edge
  task automatic wait_cycle();
    @(posedge CLK);
    #5;
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected, inout int errors);
    if (got !== expected) begin
      $display("error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
      errors++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout after %0d cycles while waiting for %s", WAIT_LIMIT, what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  function automatic int total_errors();
    return stim_errors + compare_errors;
  endfunction

  // Wrapped sum or difference with overflow from the effective operand signs
  function automatic expected_t reference_result(input ntm_word_t a, input ntm_word_t b,
                                                 input ntm_op_t op, input logic last);
    expected_t expected;
    logic      sign_b;
    // Subtract adds the inverted b
    sign_b = (op == op_sub) ? ~b[MSB] : b[MSB];
    expected.result.sum      = (op == op_sub) ? a - b : a + b;
    expected.result.overflow = (a[MSB] == sign_b) && (expected.result.sum[MSB] != a[MSB]);
    expected.last            = last;
    return expected;
  endfunction

  ////////////////////////////////////////
  // Comparing process
  ////////////////////////////////////////

  // Outputs are settled at the falling edge
  always @(negedge CLK) begin
    expected_t expected;
    if (!RST && READY && !DATA_OUT_ENABLE) begin
      $display("READY pulsed at %0t without an output", $time);
      compare_errors++;
    end
    if (!RST && DATA_OUT_ENABLE) begin
      if (expected_q.size() == 0) begin
        $display("Output at %0t with no element outstanding", $time);
        compare_errors++;
      end else begin
        expected = expected_q.pop_front();
        check_value("result", 64'(RESULT), 64'(expected.result), compare_errors);
        check_value("ready", 64'(READY), 64'(expected.last), compare_errors);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic start_vector(input ntm_index_t length);
    START   = 1'b1;
    SIZE_IN = length;
    wait_cycle();
    START   = 1'b0;
  endtask

  // Order 1 sends A first and order 2 sends B first
  // Any other order strobes both in one cycle
  task automatic send_element(input ntm_word_t a, input ntm_word_t b, input ntm_op_t op,
                              input logic last, input int order, input int gap);
    int   waited;
    logic seen;
    expected_q.push_back(reference_result(a, b, op, last));
    DATA_A_IN = a;
    DATA_B_IN = b;
    OPERATION = op;
    if (order == 1) begin
      DATA_A_IN_ENABLE = 1'b1;
      wait_cycle();
      DATA_A_IN_ENABLE = 1'b0;
      repeat (gap) wait_cycle();
      DATA_B_IN_ENABLE = 1'b1;
    end else if (order == 2) begin
      DATA_B_IN_ENABLE = 1'b1;
      wait_cycle();
      DATA_B_IN_ENABLE = 1'b0;
      repeat (gap) wait_cycle();
      DATA_A_IN_ENABLE = 1'b1;
    end else begin
      DATA_A_IN_ENABLE = 1'b1;
      DATA_B_IN_ENABLE = 1'b1;
    end
    // Cycles counted from the second operand
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < WAIT_LIMIT) begin
      wait_cycle();
      DATA_A_IN_ENABLE = 1'b0;
      DATA_B_IN_ENABLE = 1'b0;
      waited++;
      seen = DATA_OUT_ENABLE;
    end
    if (!seen) begin
      abort_on_timeout("DATA_OUT_ENABLE");
    end else begin
      check_value("latency", 64'(waited), 64'(LATENCY), stim_errors);
    end
  endtask

  task automatic run_single(input ntm_word_t a, input ntm_word_t b, input ntm_op_t op,
                            input int order);
    start_vector(ntm_index_t'(1));
    send_element(a, b, op, 1'b1, order, 1);
  endtask

  task automatic run_random_vector(input int length);
    ntm_word_t a;
    ntm_word_t b;
    ntm_op_t   op;
    int        order;
    int        gap;
    start_vector(ntm_index_t'(length));
    for (int i = 0; i < length; i++) begin
      a     = ntm_word_t'($random(seed));
      b     = ntm_word_t'($random(seed));
      op    = (($random(seed) & 1) != 0) ? op_sub : op_add;
      order = int'($unsigned($random(seed)) % 3);
      gap   = int'($unsigned($random(seed)) % 4);
      // Idle gap before each element
      repeat (1 + int'($unsigned($random(seed)) % 3)) wait_cycle();
      send_element(a, b, op, i == length - 1, order, gap);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    int errors;
    // Comparator takes the last output first
    wait_cycle();
    errors = total_errors() - errors_before;
    if (errors == 0) begin
      $display("Test %s passed", name);
      tests_passed++;
    end else begin
      $display("Test %s failed with %0d errors", name, errors);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int mark;
    CLK              = 1'b0;
    RST              = 1'b1;
    START            = 1'b0;
    OPERATION        = op_add;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    SIZE_IN          = '0;
    DATA_A_IN        = '0;
    DATA_B_IN        = '0;

    // Outputs quiet in and after reset
    mark = total_errors();
    for (int i = 0; i < 12; i++) begin
      wait_cycle();
      check_value("READY", 64'(READY), 64'(1'b0), stim_errors);
      check_value("DATA_OUT_ENABLE", 64'(DATA_OUT_ENABLE), 64'(1'b0), stim_errors);
      if (i == 7) begin
        RST = 1'b0;
      end
    end
    finish_test("reset", mark);

    mark = total_errors();
    run_single(ntm_word_t'(100), ntm_word_t'(23), op_add, 0);
    run_single(ntm_word_t'(1000), ntm_word_t'(1), op_sub, 1);
    run_single(ntm_word_t'(0), ntm_word_t'(1), op_sub, 2);
    finish_test("single element", mark);

    // Overflow corners and one mixed-sign case
    mark = total_errors();
    run_single(WORD_MAX, ntm_word_t'(1), op_add, 0);
    run_single(WORD_MIN, ntm_word_t'(1), op_sub, 1);
    run_single(WORD_MIN, WORD_MAX, op_sub, 2);
    run_single(ntm_word_t'(5), ~ntm_word_t'(6), op_add, 0);
    finish_test("overflow corners", mark);

    mark = total_errors();
    run_random_vector(16);
    finish_test("random vector", mark);

    // Second START in the READY cycle
    mark = total_errors();
    run_random_vector(1);
    run_random_vector(5);
    finish_test("back to back", mark);

    if (expected_q.size() != 0) begin
      $display("%0d expected outputs never arrived", expected_q.size());
      stim_errors++;
    end
    $display("Tests passed %0d, failed %0d, errors %0d",
             tests_passed, tests_failed, total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+.
ntm_arith_pkg.sv
ntm_ctrl_pkg.sv
ntm_scalar_integer_adder.sv
ntm_vector_integer_adder.sv
ntm_vector_integer_adder_checker.sv
ntm_vector_integer_adder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vector adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator is not installed or not on the PATH"
  exit 1
fi

# Files without their own timescale get the project one
verilator --binary --assert --timescale 1ns/10ps \
  --top-module ntm_vector_integer_adder_tb \
  -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vntm_vector_integer_adder_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
